//--- Bender.yml
package:
  name: opm_reg_top

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/opm_bus_pkg.sv
      - rtl/opm_voice_pkg.sv
      - rtl/opm_bus_sync.sv
      - rtl/opm_loreg_file.sv
      - rtl/opm_chreg_file.sv
      - rtl/opm_status_port.sv
      - rtl/opm_reg_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_opm_reg_top.sv

//--- opm_reg_top.f
+incdir+rtl
rtl/opm_bus_pkg.sv
rtl/opm_voice_pkg.sv
rtl/opm_bus_sync.sv
rtl/opm_loreg_file.sv
rtl/opm_chreg_file.sv
rtl/opm_status_port.sv
rtl/opm_reg_top.sv
sim/tb_opm_reg_top.sv

//--- rtl/opm_bus_pkg.sv
package opm_bus_pkg;

    // one byte on the cpu data bus
    typedef logic [7:0] bus_byte_t;

    // strobe between the bus synchronizer and the register blocks
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_ADDR = 2'd1,     // a0 low
        OP_DATA = 2'd2      // a0 high
    } bus_op_e;

    // low registers still implemented
    typedef enum logic [7:0] {
        REG_NOISE     = 8'h0F,  // ne, nfrq
        REG_CLKA1     = 8'h10,  // timer a high bits
        REG_CLKA2     = 8'h11,  // timer a low bits
        REG_CLKB      = 8'h12,
        REG_TIMER_CTL = 8'h14,  // run, irq enable, flag reset
        REG_LFRQ      = 8'h18,
        REG_MOD_DEPTH = 8'h19,  // pmd or amd by bit 7
        REG_WAVE      = 8'h1B
    } lo_addr_e;

endpackage

//--- rtl/opm_bus_sync.sv
`timescale 1ns/1ps
`include "opm_consts.svh"

module opm_bus_sync
    import opm_bus_pkg::*;
(
    input  logic      i_EMUCLK,
    input  logic      mrst_n,
    input  logic      i_cs_n,
    input  logic      i_wr_n,
    input  logic      i_a0,
    input  bus_byte_t i_d,
    output bus_op_e   o_op,
    output bus_byte_t o_byte
);

    localparam int STAGES = `OPM_SYNC_STAGES;

    logic [STAGES-1:0] cs_n_sync;
    logic [STAGES-1:0] wr_n_sync;
    logic [STAGES-1:0] a0_sync;
    bus_byte_t         d_sync [STAGES];

    logic      wr_act;      // cs and wr both low, synchronized
    logic      wr_act_d;
    logic      wr_start;
    logic      start_q;
    logic      start_a0;
    bus_byte_t start_byte;

    //////////////////////////////////////////////////////////////////////
    // input synchronizers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            cs_n_sync <= '1;    // bus idle
            wr_n_sync <= '1;
            a0_sync   <= '0;
        end else begin
            cs_n_sync <= {cs_n_sync[STAGES-2:0], i_cs_n};
            wr_n_sync <= {wr_n_sync[STAGES-2:0], i_wr_n};
            a0_sync   <= {a0_sync[STAGES-2:0], i_a0};
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        d_sync[0] <= i_d;
        for (int i = 1; i < STAGES; i++) begin
            d_sync[i] <= d_sync[i-1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // write detect and strobe
    //////////////////////////////////////////////////////////////////////

    assign wr_act   = ~cs_n_sync[STAGES-1] & ~wr_n_sync[STAGES-1];
    assign wr_start = wr_act & ~wr_act_d;   // first cycle of the access only

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            wr_act_d <= 1'b0;
            start_q  <= 1'b0;
            o_op     <= OP_NONE;
        end else begin
            wr_act_d <= wr_act;
            start_q  <= wr_start;
            if (start_q) begin
                o_op <= start_a0 ? OP_DATA : OP_ADDR;
            end else begin
                o_op <= OP_NONE;
            end
        end
    end

    // byte and a0 captured with the start, byte held until the next write
    always_ff @(posedge i_EMUCLK) begin
        if (wr_start) begin
            start_a0   <= a0_sync[STAGES-1];
            start_byte <= d_sync[STAGES-1];
        end
        if (start_q) begin
            o_byte <= start_byte;
        end
    end

    a_single_strobe: assert property (
        @(posedge i_EMUCLK) disable iff (!mrst_n)
        (o_op != OP_NONE) |=> (o_op == OP_NONE)
    );

endmodule

//--- rtl/opm_chreg_file.sv
`timescale 1ns/1ps
`include "opm_consts.svh"

module opm_chreg_file
    import opm_bus_pkg::*, opm_voice_pkg::*;
(
    input  logic      i_EMUCLK,
    input  logic      mrst_n,
    input  bus_op_e   i_op,
    input  bus_byte_t i_byte,
    output ch_idx_t   o_ch,
    output kc_t       o_kc,
    output kf_t       o_kf,
    output alg_t      o_alg,
    output fl_t       o_fl,
    output rl_t       o_rl,
    output pms_t      o_pms,
    output ams_t      o_ams
);

    typedef struct packed {
        rl_t  rl;
        fl_t  fl;
        alg_t alg;
        kc_t  kc;
        kf_t  kf;
        pms_t pms;
        ams_t ams;
    } ch_rec_t;

    ch_group_e pend_grp;
    ch_idx_t   pend_ch;
    bus_byte_t pend_data;
    logic      addr_vld;
    logic      data_vld;
    logic      in_window;
    logic      ch_hit;

    ch_idx_t   slot_cnt;                    // channel of the leaving stage
    ch_rec_t   store [`OPM_NUM_CH];         // stage 0 enters, last stage leaves
    ch_rec_t   rec_in;

    //////////////////////////////////////////////////////////////////////
    // pending address / data
    //////////////////////////////////////////////////////////////////////

    assign in_window = (i_byte >= `OPM_ADDR_CH_LO) && (i_byte <= `OPM_ADDR_CH_HI);

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            addr_vld <= 1'b0;
            data_vld <= 1'b0;
            slot_cnt <= '0;
        end else begin
            if (i_op == OP_ADDR) begin
                addr_vld <= in_window;
                data_vld <= 1'b0;   // old data never goes to a new address
            end else if ((i_op == OP_DATA) && addr_vld) begin
                data_vld <= 1'b1;
            end
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        if ((i_op == OP_ADDR) && in_window) begin
            pend_grp <= ch_group_e'(i_byte[4:3]);
            pend_ch  <= i_byte[`OPM_CH_BITS-1:0];
        end
        if ((i_op == OP_DATA) && addr_vld) begin
            pend_data <= i_byte;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // circulating channel store
    //////////////////////////////////////////////////////////////////////

    // recirculating record belongs to channel slot_cnt
    assign ch_hit = data_vld && (slot_cnt == pend_ch);

    always_comb begin
        rec_in = store[`OPM_NUM_CH-1];
        if (ch_hit) begin
            case (pend_grp)
                GRP_ROUTE: begin
                    rec_in.rl  = pend_data[7:6];
                    rec_in.fl  = pend_data[5:3];
                    rec_in.alg = pend_data[2:0];
                end
                GRP_KC: rec_in.kc = pend_data[6:0];
                GRP_KF: rec_in.kf = pend_data[7:2];
                GRP_MODSENS: begin
                    rec_in.pms = pend_data[6:4];
                    rec_in.ams = pend_data[1:0];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            for (int i = 0; i < `OPM_NUM_CH; i++) begin
                store[i] <= '0;
            end
        end else begin
            store[0] <= rec_in;
            for (int i = 1; i < `OPM_NUM_CH; i++) begin
                store[i] <= store[i-1];
            end
        end
    end

    assign o_ch  = slot_cnt;
    assign o_kc  = store[`OPM_NUM_CH-1].kc;
    assign o_kf  = store[`OPM_NUM_CH-1].kf;
    assign o_alg = store[`OPM_NUM_CH-1].alg;
    assign o_fl  = store[`OPM_NUM_CH-1].fl;
    assign o_rl  = store[`OPM_NUM_CH-1].rl;
    assign o_pms = store[`OPM_NUM_CH-1].pms;
    assign o_ams = store[`OPM_NUM_CH-1].ams;    // no am enable gating

    a_ch_advance: assert property (
        @(posedge i_EMUCLK) disable iff (!mrst_n)
        1'b1 |=> (o_ch == ch_idx_t'($past(o_ch) + 1'b1))
    );

endmodule

//--- rtl/opm_consts.svh
`ifndef OPM_CONSTS_SVH
`define OPM_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// channel store geometry
//////////////////////////////////////////////////////////////////////

`define OPM_NUM_CH          8
`define OPM_CH_BITS         3

// channel parameter window, 0x20..0x3F
`define OPM_ADDR_CH_LO      8'h20
`define OPM_ADDR_CH_HI      8'h3F

//////////////////////////////////////////////////////////////////////
// bus side
//////////////////////////////////////////////////////////////////////

`define OPM_SYNC_STAGES     2       // flops per bus input
`define OPM_BUSY_CYCLES     32      // write busy length in EMUCLK cycles

`endif

//--- rtl/opm_loreg_file.sv
`timescale 1ns/1ps

module opm_loreg_file
    import opm_bus_pkg::*;
(
    input  logic       i_EMUCLK,
    input  logic       mrst_n,
    input  bus_op_e    i_op,
    input  bus_byte_t  i_byte,
    output logic       o_ne,
    output logic [4:0] o_nfrq,
    output bus_byte_t  o_clka1,
    output logic [1:0] o_clka2,
    output bus_byte_t  o_clkb,
    output logic       o_timera_run,
    output logic       o_timerb_run,
    output logic       o_timera_irq_en,
    output logic       o_timerb_irq_en,
    output logic       o_timera_frst,
    output logic       o_timerb_frst,
    output bus_byte_t  o_lfrq,
    output logic       o_lfrq_update,
    output logic [6:0] o_pmd,
    output logic [6:0] o_amd,
    output logic [1:0] o_w
);

    lo_addr_e sel_addr;     // last selected low register
    logic     sel_vld;
    logic     addr_known;
    logic     data_wr;

    //////////////////////////////////////////////////////////////////////
    // address select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (i_byte)
            REG_NOISE, REG_CLKA1, REG_CLKA2, REG_CLKB,
            REG_TIMER_CTL, REG_LFRQ, REG_MOD_DEPTH, REG_WAVE: addr_known = 1'b1;
            default: addr_known = 1'b0;     // 0x08, 0x01, hi regs etc
        endcase
    end

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            sel_vld  <= 1'b0;
            sel_addr <= REG_NOISE;
        end else if (i_op == OP_ADDR) begin
            sel_vld  <= addr_known;
            sel_addr <= lo_addr_e'(i_byte);
        end
    end

    assign data_wr = (i_op == OP_DATA) && sel_vld;

    //////////////////////////////////////////////////////////////////////
    // register fields
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            o_ne            <= 1'b0;
            o_nfrq          <= '0;
            o_clka1         <= '0;
            o_clka2         <= '0;
            o_clkb          <= '0;
            o_timera_run    <= 1'b0;
            o_timerb_run    <= 1'b0;
            o_timera_irq_en <= 1'b0;
            o_timerb_irq_en <= 1'b0;
            o_timera_frst   <= 1'b1;    // flags held clear during reset
            o_timerb_frst   <= 1'b1;
            o_lfrq          <= '0;
            o_lfrq_update   <= 1'b0;
            o_pmd           <= '0;
            o_amd           <= '0;
            o_w             <= '0;
        end else begin
            o_timera_frst <= 1'b0;      // pulses
            o_timerb_frst <= 1'b0;
            o_lfrq_update <= 1'b0;
            if (data_wr) begin
                case (sel_addr)
                    REG_NOISE: begin
                        o_ne   <= i_byte[7];
                        o_nfrq <= i_byte[4:0];
                    end
                    REG_CLKA1: o_clka1 <= i_byte;
                    REG_CLKA2: o_clka2 <= i_byte[1:0];
                    REG_CLKB:  o_clkb  <= i_byte;
                    REG_TIMER_CTL: begin
                        o_timera_run    <= i_byte[0];
                        o_timerb_run    <= i_byte[1];
                        o_timera_irq_en <= i_byte[2];
                        o_timerb_irq_en <= i_byte[3];
                        o_timera_frst   <= i_byte[4];
                        o_timerb_frst   <= i_byte[5];
                    end
                    REG_LFRQ: begin
                        o_lfrq        <= i_byte;
                        o_lfrq_update <= 1'b1;  // lfo restarts its period
                    end
                    REG_MOD_DEPTH: begin
                        if (i_byte[7]) o_pmd <= i_byte[6:0];
                        else           o_amd <= i_byte[6:0];
                    end
                    REG_WAVE: o_w <= i_byte[1:0];
                    default: ;
                endcase
            end
        end
    end

    a_frst_from_data: assert property (
        @(posedge i_EMUCLK) disable iff (!mrst_n)
        ($rose(o_timera_frst) || $rose(o_timerb_frst)) |-> ($past(i_op) == OP_DATA)
    );

endmodule

//--- rtl/opm_reg_top.sv
`timescale 1ns/1ps

module opm_reg_top
    import opm_bus_pkg::*, opm_voice_pkg::*;
(
    input  logic       i_EMUCLK,
    input  logic       mrst_n,
    // cpu bus
    input  logic       i_cs_n,
    input  logic       i_wr_n,
    input  logic       i_rd_n,
    input  logic       i_a0,
    input  bus_byte_t  i_d,
    output bus_byte_t  o_d,
    output logic       o_d_oe,
    // timer flags back from the timers
    input  logic       i_timera_flag,
    input  logic       i_timerb_flag,
    // low registers
    output logic       o_ne,
    output logic [4:0] o_nfrq,
    output bus_byte_t  o_clka1,
    output logic [1:0] o_clka2,
    output bus_byte_t  o_clkb,
    output logic       o_timera_run,
    output logic       o_timerb_run,
    output logic       o_timera_irq_en,
    output logic       o_timerb_irq_en,
    output logic       o_timera_frst,
    output logic       o_timerb_frst,
    output bus_byte_t  o_lfrq,
    output logic       o_lfrq_update,
    output logic [6:0] o_pmd,
    output logic [6:0] o_amd,
    output logic [1:0] o_w,
    // channel parameters, one channel per cycle
    output ch_idx_t    o_ch,
    output kc_t        o_kc,
    output kf_t        o_kf,
    output alg_t       o_alg,
    output fl_t        o_fl,
    output rl_t        o_rl,
    output pms_t       o_pms,
    output ams_t       o_ams
);

    bus_op_e   bus_op;
    bus_byte_t bus_byte;

    opm_bus_sync i_bus_sync (
        .i_EMUCLK (i_EMUCLK),
        .mrst_n   (mrst_n),
        .i_cs_n   (i_cs_n),
        .i_wr_n   (i_wr_n),
        .i_a0     (i_a0),
        .i_d      (i_d),
        .o_op     (bus_op),
        .o_byte   (bus_byte)
    );

    opm_loreg_file i_loreg_file (
        .i_EMUCLK        (i_EMUCLK),
        .mrst_n          (mrst_n),
        .i_op            (bus_op),
        .i_byte          (bus_byte),
        .o_ne            (o_ne),
        .o_nfrq          (o_nfrq),
        .o_clka1         (o_clka1),
        .o_clka2         (o_clka2),
        .o_clkb          (o_clkb),
        .o_timera_run    (o_timera_run),
        .o_timerb_run    (o_timerb_run),
        .o_timera_irq_en (o_timera_irq_en),
        .o_timerb_irq_en (o_timerb_irq_en),
        .o_timera_frst   (o_timera_frst),
        .o_timerb_frst   (o_timerb_frst),
        .o_lfrq          (o_lfrq),
        .o_lfrq_update   (o_lfrq_update),
        .o_pmd           (o_pmd),
        .o_amd           (o_amd),
        .o_w             (o_w)
    );

    opm_chreg_file i_chreg_file (
        .i_EMUCLK (i_EMUCLK),
        .mrst_n   (mrst_n),
        .i_op     (bus_op),
        .i_byte   (bus_byte),
        .o_ch     (o_ch),
        .o_kc     (o_kc),
        .o_kf     (o_kf),
        .o_alg    (o_alg),
        .o_fl     (o_fl),
        .o_rl     (o_rl),
        .o_pms    (o_pms),
        .o_ams    (o_ams)
    );

    opm_status_port i_status_port (
        .i_EMUCLK      (i_EMUCLK),
        .mrst_n        (mrst_n),
        .i_op          (bus_op),
        .i_cs_n        (i_cs_n),
        .i_rd_n        (i_rd_n),
        .i_a0          (i_a0),
        .i_timera_flag (i_timera_flag),
        .i_timerb_flag (i_timerb_flag),
        .o_d           (o_d),
        .o_d_oe        (o_d_oe)
    );

endmodule

//--- rtl/opm_status_port.sv
`timescale 1ns/1ps
`include "opm_consts.svh"

module opm_status_port
    import opm_bus_pkg::*;
(
    input  logic      i_EMUCLK,
    input  logic      mrst_n,
    input  bus_op_e   i_op,
    input  logic      i_cs_n,
    input  logic      i_rd_n,
    input  logic      i_a0,
    input  logic      i_timera_flag,
    input  logic      i_timerb_flag,
    output bus_byte_t o_d,
    output logic      o_d_oe
);

    localparam int BUSY_W = $clog2(`OPM_BUSY_CYCLES + 1);

    logic [BUSY_W-1:0] busy_cnt;
    logic              write_busy;

    // every data write restarts the busy window
    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            busy_cnt <= '0;
        end else if (i_op == OP_DATA) begin
            busy_cnt <= BUSY_W'(`OPM_BUSY_CYCLES);
        end else if (write_busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign write_busy = (busy_cnt != '0);

    assign o_d    = {write_busy, 5'b00000, i_timerb_flag, i_timera_flag};
    assign o_d_oe = ~i_cs_n & ~i_rd_n & ~i_a0 & mrst_n;    // status read only at a0 low

    a_busy_bound: assert property (
        @(posedge i_EMUCLK) disable iff (!mrst_n)
        busy_cnt <= BUSY_W'(`OPM_BUSY_CYCLES)
    );

endmodule

//--- rtl/opm_voice_pkg.sv
`include "opm_consts.svh"

package opm_voice_pkg;

    typedef logic [`OPM_CH_BITS-1:0] ch_idx_t;

    // address bits 4:3 inside the channel window
    typedef enum logic [1:0] {
        GRP_ROUTE   = 2'd0,     // 0x20: rl 7:6, fl 5:3, alg 2:0
        GRP_KC      = 2'd1,     // 0x28: kc 6:0
        GRP_KF      = 2'd2,     // 0x30: kf 7:2
        GRP_MODSENS = 2'd3      // 0x38: pms 6:4, ams 1:0
    } ch_group_e;

    //////////////////////////////////////////////////////////////////////
    // per channel fields
    //////////////////////////////////////////////////////////////////////

    typedef logic [6:0] kc_t;   // key code
    typedef logic [5:0] kf_t;   // key fraction
    typedef logic [2:0] alg_t;  // connection
    typedef logic [2:0] fl_t;   // feedback level
    typedef logic [1:0] rl_t;   // right/left enable
    typedef logic [2:0] pms_t;
    typedef logic [1:0] ams_t;

endpackage

//--- sim/tb_opm_reg_top.sv
`timescale 1ns/1ps
`include "opm_consts.svh"

module tb_opm_reg_top
    import opm_bus_pkg::*, opm_voice_pkg::*;
();

    localparam int TEST_CYCLES    = 2000;   // ~110 bus phases of 8 cycles plus waits rounded up
    localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES;

    typedef struct packed {
        logic       ne;
        logic [4:0] nfrq;
        bus_byte_t  clka1;
        logic [1:0] clka2;
        bus_byte_t  clkb;
        logic       ta_run;
        logic       tb_run;
        logic       ta_irq;
        logic       tb_irq;
        bus_byte_t  lfrq;
        logic [6:0] pmd;
        logic [6:0] amd;
        logic [1:0] w;
    } lo_regs_t;

    logic i_EMUCLK, mrst_n, i_cs_n, i_wr_n, i_rd_n, i_a0;
    logic i_timera_flag, i_timerb_flag;
    bus_byte_t i_d, o_d, o_clka1, o_clkb, o_lfrq;
    logic o_d_oe, o_ne, o_timera_run, o_timerb_run, o_timera_irq_en, o_timerb_irq_en;
    logic o_timera_frst, o_timerb_frst, o_lfrq_update;
    logic [4:0] o_nfrq;
    logic [1:0] o_clka2, o_w;
    logic [6:0] o_pmd, o_amd;
    ch_idx_t o_ch;
    kc_t o_kc;
    kf_t o_kf;
    alg_t o_alg;
    fl_t o_fl;
    rl_t o_rl;
    pms_t o_pms;
    ams_t o_ams;

    lo_regs_t exp_lo;
    kc_t  exp_kc  [`OPM_NUM_CH];    // expected record per channel
    kf_t  exp_kf  [`OPM_NUM_CH];
    alg_t exp_alg [`OPM_NUM_CH];
    fl_t  exp_fl  [`OPM_NUM_CH];
    rl_t  exp_rl  [`OPM_NUM_CH];
    pms_t exp_pms [`OPM_NUM_CH];
    ams_t exp_ams [`OPM_NUM_CH];

    logic [31:0] rng_state;
    logic        ch_check_en;
    logic [`OPM_NUM_CH-1:0] ch_seen;
    int frsta_cycles, frstb_cycles, upd_cycles;
    int mismatch_cnt, other_err_cnt, cycle_cnt;

    opm_reg_top i_opm_reg_top (.*);

    initial begin
        i_EMUCLK = 1'b0;
        forever #2 i_EMUCLK = ~i_EMUCLK;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic bus_byte_t rand_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[15:8];
    endfunction

    // low register fields after a data byte to addr
    function automatic lo_regs_t lo_model(input lo_regs_t cur, input bus_byte_t addr,
                                          input bus_byte_t data);
        lo_regs_t nxt;
        nxt = cur;
        case (addr)
            REG_NOISE: begin
                nxt.ne   = data[7];
                nxt.nfrq = data[4:0];
            end
            REG_CLKA1: nxt.clka1 = data;
            REG_CLKA2: nxt.clka2 = data[1:0];
            REG_CLKB:  nxt.clkb  = data;
            REG_TIMER_CTL: begin
                nxt.ta_run = data[0];
                nxt.tb_run = data[1];
                nxt.ta_irq = data[2];
                nxt.tb_irq = data[3];
            end
            REG_LFRQ: nxt.lfrq = data;
            REG_MOD_DEPTH: begin
                if (data[7])
                    nxt.pmd = data[6:0];
                else
                    nxt.amd = data[6:0];
            end
            REG_WAVE: nxt.w = data[1:0];
            default: ;  // dropped or unknown address
        endcase
        return nxt;
    endfunction

    function automatic bus_byte_t lo_addr_at(input int i);
        case (i)
            0: return REG_NOISE;
            1: return REG_CLKA1;
            2: return REG_CLKA2;
            3: return REG_CLKB;
            4: return REG_TIMER_CTL;
            5: return REG_LFRQ;
            6: return REG_MOD_DEPTH;
            default: return REG_WAVE;
        endcase
    endfunction

    task automatic apply_ch_model(input ch_group_e grp, input ch_idx_t ch, input bus_byte_t data);
        case (grp)
            GRP_ROUTE: begin
                exp_rl[ch]  = data[7:6];
                exp_fl[ch]  = data[5:3];
                exp_alg[ch] = data[2:0];
            end
            GRP_KC: exp_kc[ch] = data[6:0];
            GRP_KF: exp_kf[ch] = data[7:2];
            default: begin
                exp_pms[ch] = data[6:4];
                exp_ams[ch] = data[1:0];
            end
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_byte(input string name, input bus_byte_t got, input bus_byte_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%02h expected 0x%02h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    // narrower voice fields widen into kc_t
    task automatic check_field(input string name, input kc_t got, input kc_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%02h expected 0x%02h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_pulse(input string name, input int seen, input int exp);
        if (seen != exp) begin
            $display("%s was high for %0d cycles where %0d were expected", name, seen, exp);
            other_err_cnt++;
        end
    endtask

    task automatic check_lo_regs();
        check_bit("o_ne", o_ne, exp_lo.ne);
        check_field("o_nfrq", o_nfrq, exp_lo.nfrq);
        check_byte("o_clka1", o_clka1, exp_lo.clka1);
        check_field("o_clka2", o_clka2, exp_lo.clka2);
        check_byte("o_clkb", o_clkb, exp_lo.clkb);
        check_bit("o_timera_run", o_timera_run, exp_lo.ta_run);
        check_bit("o_timerb_run", o_timerb_run, exp_lo.tb_run);
        check_bit("o_timera_irq_en", o_timera_irq_en, exp_lo.ta_irq);
        check_bit("o_timerb_irq_en", o_timerb_irq_en, exp_lo.tb_irq);
        check_byte("o_lfrq", o_lfrq, exp_lo.lfrq);
        check_field("o_pmd", o_pmd, exp_lo.pmd);
        check_field("o_amd", o_amd, exp_lo.amd);
        check_field("o_w", o_w, exp_lo.w);
        check_bit("o_timera_frst", o_timera_frst, 1'b0);    // pulses over by now
        check_bit("o_timerb_frst", o_timerb_frst, 1'b0);
        check_bit("o_lfrq_update", o_lfrq_update, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus tasks called 1 ns after a rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic idle(input int n);
        repeat (n) @(posedge i_EMUCLK);
        #1;
    endtask

    task automatic bus_write(input logic a0, input bus_byte_t data);
        i_cs_n = 1'b0;
        i_wr_n = 1'b0;
        i_a0   = a0;
        i_d    = data;
        idle(4);
        i_cs_n = 1'b1;
        i_wr_n = 1'b1;
        idle(4);
    endtask

    task automatic bus_read(input logic a0, output bus_byte_t data, output logic oe);
        i_cs_n = 1'b0;
        i_rd_n = 1'b0;
        i_a0   = a0;
        repeat (3) @(posedge i_EMUCLK);
        @(negedge i_EMUCLK);
        data = o_d;     // last cycle of the read phase
        oe   = o_d_oe;
        idle(1);
        i_cs_n = 1'b1;
        i_rd_n = 1'b1;
        idle(4);
    endtask

    task automatic watch_channels();
        idle(24);   // worst case store latency plus margin
        ch_seen     = '0;
        ch_check_en = 1'b1;
        idle(`OPM_NUM_CH);
        ch_check_en = 1'b0;
        if (ch_seen != '1) begin
            $display("channel window missed channels, seen mask 0x%02h", ch_seen);
            other_err_cnt++;
        end
    endtask

    // pulse counters and channel compare sampled mid cycle
    always @(negedge i_EMUCLK) begin
        if (o_timera_frst) frsta_cycles++;
        if (o_timerb_frst) frstb_cycles++;
        if (o_lfrq_update) upd_cycles++;
        if (ch_check_en) begin
            ch_seen[o_ch] = 1'b1;
            check_field($sformatf("o_kc ch%0d", o_ch), o_kc, exp_kc[o_ch]);
            check_field($sformatf("o_kf ch%0d", o_ch), o_kf, exp_kf[o_ch]);
            check_field($sformatf("o_alg ch%0d", o_ch), o_alg, exp_alg[o_ch]);
            check_field($sformatf("o_fl ch%0d", o_ch), o_fl, exp_fl[o_ch]);
            check_field($sformatf("o_rl ch%0d", o_ch), o_rl, exp_rl[o_ch]);
            check_field($sformatf("o_pms ch%0d", o_ch), o_pms, exp_pms[o_ch]);
            check_field($sformatf("o_ams ch%0d", o_ch), o_ams, exp_ams[o_ch]);
        end
    end

    always @(posedge i_EMUCLK) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        bus_byte_t addr;
        bus_byte_t data;
        logic      oe;
        logic      fa;
        logic      fb;

        rng_state = 32'd11011;
        mismatch_cnt = 0;
        other_err_cnt = 0;
        cycle_cnt = 0;
        ch_check_en = 1'b0;
        ch_seen = '0;
        exp_lo = '0;
        for (int c = 0; c < `OPM_NUM_CH; c++) begin
            exp_kc[c] = '0;
            exp_kf[c] = '0;
            exp_alg[c] = '0;
            exp_fl[c] = '0;
            exp_rl[c] = '0;
            exp_pms[c] = '0;
            exp_ams[c] = '0;
        end
        mrst_n = 1'b0;
        i_cs_n = 1'b1;
        i_wr_n = 1'b1;
        i_rd_n = 1'b1;
        i_a0 = 1'b0;
        i_d = '0;
        i_timera_flag = 1'b0;
        i_timerb_flag = 1'b0;

        // frst held high during reset
        @(negedge i_EMUCLK);
        check_bit("o_timera_frst", o_timera_frst, 1'b1);
        check_bit("o_timerb_frst", o_timerb_frst, 1'b1);
        @(posedge i_EMUCLK);
        #1;
        mrst_n = 1'b1;
        idle(2);
        check_lo_regs();
        check_byte("o_d", o_d, 8'h00);
        check_bit("o_d_oe", o_d_oe, 1'b0);

        // low registers in two rounds
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 8; i++) begin
                addr = lo_addr_at(i);
                data = rand_byte();
                if (addr == REG_MOD_DEPTH) data[7] = (r == 0);   // pmd then amd
                if (addr == REG_TIMER_CTL && r == 0) data[5:4] = 2'b11;
                bus_write(1'b0, addr);
                frsta_cycles = 0;
                frstb_cycles = 0;
                upd_cycles = 0;
                bus_write(1'b1, data);
                exp_lo = lo_model(exp_lo, addr, data);
                check_lo_regs();
                check_pulse("o_timera_frst", frsta_cycles,
                            (addr == REG_TIMER_CTL && data[4]) ? 1 : 0);
                check_pulse("o_timerb_frst", frstb_cycles,
                            (addr == REG_TIMER_CTL && data[5]) ? 1 : 0);
                check_pulse("o_lfrq_update", upd_cycles, (addr == REG_LFRQ) ? 1 : 0);
            end
        end

        // dropped key-on address
        bus_write(1'b0, 8'h08);
        bus_write(1'b1, {6'h3F, ~exp_lo.w});    // unlike the current wave bits
        check_lo_regs();

        // every group of every channel
        for (int g = 0; g < 4; g++) begin
            for (int c = 0; c < `OPM_NUM_CH; c++) begin
                addr = `OPM_ADDR_CH_LO + {g[1:0], c[2:0]};
                data = rand_byte();
                bus_write(1'b0, addr);
                bus_write(1'b1, data);
                apply_ch_model(ch_group_e'(g), ch_idx_t'(c), data);
            end
        end
        watch_channels();

        // lone data bytes after a low address go to clkb only
        bus_write(1'b0, REG_CLKB);
        for (int k = 0; k < 2; k++) begin
            data = rand_byte();
            bus_write(1'b1, data);
            exp_lo = lo_model(exp_lo, REG_CLKB, data);
        end
        watch_channels();
        check_lo_regs();

        // status read with busy right after a data write
        data = rand_byte();
        bus_write(1'b0, REG_WAVE);
        bus_write(1'b1, data);
        exp_lo = lo_model(exp_lo, REG_WAVE, data);
        fa = rng_state[0];
        fb = rng_state[1];
        i_timera_flag = fa;
        i_timerb_flag = fb;
        check_bit("o_d_oe", o_d_oe, 1'b0);
        bus_read(1'b0, data, oe);
        check_byte("o_d", data, {1'b1, 5'b00000, fb, fa});
        check_bit("o_d_oe", oe, 1'b1);
        idle(50);
        i_timera_flag = ~fa;
        i_timerb_flag = fb;
        bus_read(1'b0, data, oe);
        check_byte("o_d", data, {1'b0, 5'b00000, fb, ~fa});
        check_bit("o_d_oe", oe, 1'b1);
        bus_read(1'b1, data, oe);   // bus stays off with a0 high
        check_bit("o_d_oe", oe, 1'b0);
        check_lo_regs();

        $display("mismatches: %0d  other errors: %0d", mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
